// ==== common/frontend_pkg.sv ====
// RV32I base encodings only; compressed forms all decode as OP_INVALID
`default_nettype none

package frontend_pkg;

  // Data and address width
  localparam int XLEN = 32;

  // Register index width
  localparam int REG_W = 5;

  // Instruction class
  typedef enum logic [3:0] {
    OP_LUI,
    OP_AUIPC,
    OP_JAL,
    OP_JALR,
    OP_BRANCH,
    OP_LOAD,
    OP_STORE,
    OP_IMM,
    OP_REG,
    OP_FENCE,
    OP_SYSTEM,
    OP_INVALID
  } opcode_e;

  // Uncompressed instructions end in binary 11
  localparam logic [1:0] OPC_LOW_BITS = 2'b11;

  // Major opcode patterns, instruction bits 6 to 2
  localparam logic [4:0] OPC_LUI    = 5'b01101;
  localparam logic [4:0] OPC_AUIPC  = 5'b00101;
  localparam logic [4:0] OPC_JAL    = 5'b11011;
  localparam logic [4:0] OPC_JALR   = 5'b11001;
  localparam logic [4:0] OPC_BRANCH = 5'b11000;
  localparam logic [4:0] OPC_LOAD   = 5'b00000;
  localparam logic [4:0] OPC_STORE  = 5'b01000;
  localparam logic [4:0] OPC_IMM    = 5'b00100;
  localparam logic [4:0] OPC_REG    = 5'b01100;
  localparam logic [4:0] OPC_FENCE  = 5'b00011;
  localparam logic [4:0] OPC_SYSTEM = 5'b11100;

  // Decoded-instruction defaults for unused fields
  localparam logic [XLEN-1:0]  IMM_NONE = '0;
  localparam logic [REG_W-1:0] REG_NONE = '0;

endpackage

`default_nettype wire

// ==== hw/fetch_loader.sv ====
// One read in flight at a time; the queue must accept every push the credits allow
`timescale 1ns/100ps
`default_nettype none

module fetch_loader #(
  parameter int                          QUEUE_DEPTH = 4,
  parameter logic [frontend_pkg::XLEN-1:0] RESET_ADDR  = 32'h0000_0000
) (
  input  wire logic                          i_clock,
  input  wire logic                          i_reset,
  input  wire logic                          i_jmp_write,
  input  wire logic                          i_cache_hit,
  input  wire logic                          i_credit,
  input  wire logic [frontend_pkg::XLEN-1:0] i_jmp_address,
  input  wire logic [frontend_pkg::XLEN-1:0] i_cache_instr,
  output logic                               o_cache_read,
  output logic                               o_push,
  output logic      [frontend_pkg::XLEN-1:0] o_cache_address,
  output logic      [frontend_pkg::XLEN-1:0] o_push_addr,
  output logic      [frontend_pkg::XLEN-1:0] o_push_instr
);
  import frontend_pkg::*;

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  typedef enum logic {
    ST_IDLE,
    ST_REQ
  } state_e;

  state_e           state;
  logic [XLEN-1:0]  pc;
  logic [CNT_W-1:0] credits;
  logic             start;

  // Start a read when idle and a queue slot is free
  assign start = (state == ST_IDLE) && (credits != '0);

  assign o_cache_read    = (state == ST_REQ);
  assign o_cache_address = pc;

  // Response of a read dropped by a jump never reaches the queue
  assign o_push       = (state == ST_REQ) && i_cache_hit && !i_jmp_write;
  assign o_push_addr  = pc;
  assign o_push_instr = i_cache_instr;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state   <= ST_IDLE;
      pc      <= RESET_ADDR;
      credits <= CNT_W'(QUEUE_DEPTH);
    end else if (i_jmp_write) begin
      // Queue is flushed too, so every slot is free again
      state   <= ST_REQ;
      pc      <= i_jmp_address;
      credits <= CNT_W'(QUEUE_DEPTH - 1);
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (i_cache_hit) begin
            state <= ST_IDLE;
            pc    <= pc + XLEN'(4);
          end
        end
        default: state <= ST_IDLE;
      endcase
      // Reserve on start, refund on returned credit
      if (start && !i_credit) begin
        credits <= credits - 1'b1;
      end else if (!start && i_credit) begin
        credits <= credits + 1'b1;
      end
    end
  end

  a_credit_bound : assert property (
    @(posedge i_clock) disable iff (i_reset)
    credits <= CNT_W'(QUEUE_DEPTH)
  );

  a_addr_stable : assert property (
    @(posedge i_clock) disable iff (i_reset)
    o_cache_read && !i_cache_hit && !i_jmp_write |=> o_cache_read && $stable(o_cache_address)
  );

endmodule

`default_nettype wire

// ==== instr_queue/instr_queue.sv ====
// Push and pop never coincide with a flush from the producer side; depth of 2 or more
`timescale 1ns/100ps
`default_nettype none

module instr_queue #(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic                          i_clock,
  input  wire logic                          i_reset,
  input  wire logic                          i_flush,
  input  wire logic                          i_push,
  input  wire logic                          i_pop,
  input  wire logic [frontend_pkg::XLEN-1:0] i_push_addr,
  input  wire logic [frontend_pkg::XLEN-1:0] i_push_instr,
  output logic                               o_head_valid,
  output logic                               o_credit,
  output logic      [frontend_pkg::XLEN-1:0] o_head_addr,
  output logic      [frontend_pkg::XLEN-1:0] o_head_instr
);
  import frontend_pkg::*;

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [XLEN-1:0]  mem_addr [QUEUE_DEPTH];
  logic [XLEN-1:0]  mem_instr[QUEUE_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign o_head_valid = (count != '0);
  assign o_head_addr  = mem_addr[rd_ptr];
  assign o_head_instr = mem_instr[rd_ptr];

  // Count alone says which entries are valid
  always_ff @(posedge i_clock) begin
    if (i_push) begin
      mem_addr[wr_ptr]  <= i_push_addr;
      mem_instr[wr_ptr] <= i_push_instr;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset || i_flush) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_credit <= 1'b0;
    end else begin
      // Pointers wrap at the depth, which need not be a power of two
      if (i_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (i_push && !i_pop) begin
        count <= count + 1'b1;
      end else if (!i_push && i_pop) begin
        count <= count - 1'b1;
      end
      // One slot freed, one credit back to the loader
      o_credit <= i_pop;
    end
  end

  a_no_push_full : assert property (
    @(posedge i_clock) disable iff (i_reset || i_flush)
    i_push |-> (count < CNT_W'(QUEUE_DEPTH)) || i_pop
  );

  a_no_pop_empty : assert property (
    @(posedge i_clock) disable iff (i_reset || i_flush)
    i_pop |-> o_head_valid
  );

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
// Single lane; the renamer must return exactly one credit per beat it receives
`timescale 1ns/100ps
`default_nettype none

module instr_decoder #(
  parameter int DOWN_CREDITS = 2
) (
  input  wire logic                           i_clock,
  input  wire logic                           i_reset,
  input  wire logic                           i_flush,
  input  wire logic                           i_head_valid,
  input  wire logic                           i_dec_credit,
  input  wire logic [frontend_pkg::XLEN-1:0]  i_head_addr,
  input  wire logic [frontend_pkg::XLEN-1:0]  i_head_instr,
  output logic                                o_pop,
  output logic                                o_dec_valid,
  output logic                                o_dec_invalid,
  output frontend_pkg::opcode_e               o_dec_opcode,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rd,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rs1,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rs2,
  output logic      [frontend_pkg::XLEN-1:0]  o_dec_imm,
  output logic      [frontend_pkg::XLEN-1:0]  o_dec_address
);
  import frontend_pkg::*;

  localparam int CNT_W = $clog2(DOWN_CREDITS + 1);

  logic [CNT_W-1:0] credits;
  opcode_e          opcode;
  logic [XLEN-1:0]  imm;
  logic [REG_W-1:0] rd;
  logic [REG_W-1:0] rs2;

  // No pop in a flush cycle, so the following cycle carries no beat
  assign o_pop = i_head_valid && (credits != '0) && !i_flush;

  // Opcode class from bits 6 to 0
  always_comb begin
    opcode = OP_INVALID;
    if (i_head_instr[1:0] == OPC_LOW_BITS) begin
      case (i_head_instr[6:2])
        OPC_LUI:    opcode = OP_LUI;
        OPC_AUIPC:  opcode = OP_AUIPC;
        OPC_JAL:    opcode = OP_JAL;
        OPC_JALR:   opcode = OP_JALR;
        OPC_BRANCH: opcode = OP_BRANCH;
        OPC_LOAD:   opcode = OP_LOAD;
        OPC_STORE:  opcode = OP_STORE;
        OPC_IMM:    opcode = OP_IMM;
        OPC_REG:    opcode = OP_REG;
        OPC_FENCE:  opcode = OP_FENCE;
        OPC_SYSTEM: opcode = OP_SYSTEM;
        default:    opcode = OP_INVALID;
      endcase
    end
  end

  // Immediate format follows the class
  always_comb begin
    case (opcode)
      OP_LUI, OP_AUIPC: begin
        imm = {i_head_instr[31:12], 12'b0};
      end
      OP_JAL: begin
        imm = {{11{i_head_instr[31]}}, i_head_instr[31], i_head_instr[19:12],
               i_head_instr[20], i_head_instr[30:21], 1'b0};
      end
      OP_BRANCH: begin
        imm = {{19{i_head_instr[31]}}, i_head_instr[31], i_head_instr[7],
               i_head_instr[30:25], i_head_instr[11:8], 1'b0};
      end
      OP_STORE: begin
        imm = {{20{i_head_instr[31]}}, i_head_instr[31:25], i_head_instr[11:7]};
      end
      OP_JALR, OP_LOAD, OP_IMM, OP_FENCE, OP_SYSTEM: begin
        imm = {{20{i_head_instr[31]}}, i_head_instr[31:20]};
      end
      default: imm = IMM_NONE;
    endcase
  end

  // Branches and stores write no register
  assign rd = (opcode == OP_BRANCH || opcode == OP_STORE || opcode == OP_INVALID) ?
              REG_NONE : i_head_instr[11:7];
  assign rs2 = (opcode == OP_BRANCH || opcode == OP_STORE || opcode == OP_REG) ?
               i_head_instr[24:20] : REG_NONE;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_dec_valid <= 1'b0;
      credits     <= CNT_W'(DOWN_CREDITS);
    end else begin
      o_dec_valid <= o_pop;
      // Credit is spent at the pop that makes the beat
      if (o_pop && !i_dec_credit) begin
        credits <= credits - 1'b1;
      end else if (!o_pop && i_dec_credit) begin
        credits <= credits + 1'b1;
      end
    end
  end

  // Payload registers, loaded only with a beat
  always_ff @(posedge i_clock) begin
    if (o_pop) begin
      o_dec_opcode  <= opcode;
      o_dec_invalid <= (opcode == OP_INVALID);
      o_dec_rd      <= rd;
      o_dec_rs1     <= i_head_instr[19:15];
      o_dec_rs2     <= rs2;
      o_dec_imm     <= imm;
      o_dec_address <= i_head_addr;
    end
  end

  a_credit_bound : assert property (
    @(posedge i_clock) disable iff (i_reset)
    credits <= CNT_W'(DOWN_CREDITS)
  );

endmodule

`default_nettype wire

// ==== hw/frontend_top.sv ====
// Single-lane RV32I front end; cache must hold i_cache_instr valid in the hit cycle
`timescale 1ns/100ps
`default_nettype none

module frontend_top #(
  parameter int                            QUEUE_DEPTH  = 4,
  parameter int                            DOWN_CREDITS = 2,
  parameter logic [frontend_pkg::XLEN-1:0] RESET_ADDR   = 32'h0000_0000
) (
  input  wire logic                           i_clock,
  input  wire logic                           i_reset,
  input  wire logic [frontend_pkg::XLEN-1:0]  i_cache_instr,
  input  wire logic                           i_cache_hit,
  output logic      [frontend_pkg::XLEN-1:0]  o_cache_address,
  output logic                                o_cache_read,
  input  wire logic                           i_jmp_write,
  input  wire logic [frontend_pkg::XLEN-1:0]  i_jmp_address,
  input  wire logic                           i_dec_credit,
  output logic                                o_dec_valid,
  output logic                                o_dec_invalid,
  output frontend_pkg::opcode_e               o_dec_opcode,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rd,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rs1,
  output logic      [frontend_pkg::REG_W-1:0] o_dec_rs2,
  output logic      [frontend_pkg::XLEN-1:0]  o_dec_imm,
  output logic      [frontend_pkg::XLEN-1:0]  o_dec_address
);
  import frontend_pkg::*;

  // Loader to queue
  logic            q_push;
  logic [XLEN-1:0] q_push_addr;
  logic [XLEN-1:0] q_push_instr;
  logic            q_credit;

  // Queue to decoder
  logic            q_head_valid;
  logic [XLEN-1:0] q_head_addr;
  logic [XLEN-1:0] q_head_instr;
  logic            q_pop;

  fetch_loader #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .RESET_ADDR (RESET_ADDR)
  ) u_fetch_loader (
    .i_clock        (i_clock),
    .i_reset        (i_reset),
    .i_jmp_write    (i_jmp_write),
    .i_cache_hit    (i_cache_hit),
    .i_credit       (q_credit),
    .i_jmp_address  (i_jmp_address),
    .i_cache_instr  (i_cache_instr),
    .o_cache_read   (o_cache_read),
    .o_push         (q_push),
    .o_cache_address(o_cache_address),
    .o_push_addr    (q_push_addr),
    .o_push_instr   (q_push_instr)
  );

  instr_queue #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
  ) u_instr_queue (
    .i_clock     (i_clock),
    .i_reset     (i_reset),
    .i_flush     (i_jmp_write),
    .i_push      (q_push),
    .i_pop       (q_pop),
    .i_push_addr (q_push_addr),
    .i_push_instr(q_push_instr),
    .o_head_valid(q_head_valid),
    .o_credit    (q_credit),
    .o_head_addr (q_head_addr),
    .o_head_instr(q_head_instr)
  );

  instr_decoder #(
    .DOWN_CREDITS(DOWN_CREDITS)
  ) u_instr_decoder (
    .i_clock      (i_clock),
    .i_reset      (i_reset),
    .i_flush      (i_jmp_write),
    .i_head_valid (q_head_valid),
    .i_dec_credit (i_dec_credit),
    .i_head_addr  (q_head_addr),
    .i_head_instr (q_head_instr),
    .o_pop        (q_pop),
    .o_dec_valid  (o_dec_valid),
    .o_dec_invalid(o_dec_invalid),
    .o_dec_opcode (o_dec_opcode),
    .o_dec_rd     (o_dec_rd),
    .o_dec_rs1    (o_dec_rs1),
    .o_dec_rs2    (o_dec_rs2),
    .o_dec_imm    (o_dec_imm),
    .o_dec_address(o_dec_address)
  );

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Free-running clock from time zero; reset is released on a rising edge after RESET_CYCLES
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 20,
  parameter int RESET_CYCLES = 8
) (
  output logic o_clock,
  output logic o_reset
);

  initial begin
    o_clock = 1'b0;
    forever #HALF_PERIOD o_clock = ~o_clock;
  end

  initial begin
    o_reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clock);
    o_reset <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/tb_frontend.sv ====
// Single configuration (depth 4, two downstream credits); cache answers a read 1 to 4 edges late
`timescale 1ns/100ps
`default_nettype none

module tb_frontend;
  import frontend_pkg::*;

  localparam int          QUEUE_DEPTH  = 4;
  localparam int          DOWN_CREDITS = 2;
  localparam logic [31:0] RESET_ADDR   = 32'h0000_0080;
  localparam logic [31:0] JUMP_BASE    = 32'h0000_4000;
  localparam logic [31:0] LFSR_TAPS    = 32'h8020_0003;

  typedef struct packed {
    opcode_e     opcode;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        invalid;
  } dec_t;

  logic        clock;
  logic        reset;
  logic        cache_hit   = 1'b0;
  logic [31:0] cache_instr = 32'h0;
  logic        jmp_write   = 1'b0;
  logic [31:0] jmp_address = 32'h0;
  logic        dec_credit  = 1'b0;
  logic        cache_read;
  logic [31:0] cache_address;
  logic        dec_valid;
  logic        dec_invalid;
  opcode_e     dec_opcode;
  logic [4:0]  dec_rd;
  logic [4:0]  dec_rs1;
  logic [4:0]  dec_rs2;
  logic [31:0] dec_imm;
  logic [31:0] dec_address;

  // Stimulus and model state
  logic [31:0] lfsr        = 32'h872d;
  logic        credit_hold = 1'b0;
  logic        jump_enable = 1'b0;
  logic        cache_busy  = 1'b0;
  int          cache_delay = 0;
  int          credit_due[$];
  int          jumps_done  = 0;

  // Checker state
  logic [31:0] expected_addr = RESET_ADDR;
  logic [31:0] prev_address  = 32'h0;
  logic        read_waiting  = 1'b0;
  logic        reset_seen    = 1'b0;
  int          outstanding   = 0;
  int          beats_checked = 0;
  int          invalid_seen  = 0;

  tb_clock_gen #(.HALF_PERIOD(20), .RESET_CYCLES(8)) u_clock_gen (
    .o_clock(clock),
    .o_reset(reset)
  );

  frontend_top #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .DOWN_CREDITS(DOWN_CREDITS),
    .RESET_ADDR  (RESET_ADDR)
  ) i_frontend_top (
    .i_clock        (clock),
    .i_reset        (reset),
    .i_cache_instr  (cache_instr),
    .i_cache_hit    (cache_hit),
    .o_cache_address(cache_address),
    .o_cache_read   (cache_read),
    .i_jmp_write    (jmp_write),
    .i_jmp_address  (jmp_address),
    .i_dec_credit   (dec_credit),
    .o_dec_valid    (dec_valid),
    .o_dec_invalid  (dec_invalid),
    .o_dec_opcode   (dec_opcode),
    .o_dec_rd       (dec_rd),
    .o_dec_rs1      (dec_rs1),
    .o_dec_rs2      (dec_rs2),
    .o_dec_imm      (dec_imm),
    .o_dec_address  (dec_address)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          k;
    r = 32'h0;
    for (k = 0; k < n; k++) begin
      r    = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    end
    return r;
  endfunction

  // Opcode picked by address bits and upper bits hashed from the whole address
  function automatic logic [31:0] cache_word(input logic [31:0] addr);
    logic [31:0] mix;
    logic [6:0]  opc;
    mix = (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    case (addr[5:2] ^ addr[9:6])
      4'd0:    opc = 7'b0110111;
      4'd1:    opc = 7'b0010111;
      4'd2:    opc = 7'b1101111;
      4'd3:    opc = 7'b1100111;
      4'd4:    opc = 7'b1100011;
      4'd5:    opc = 7'b0000011;
      4'd6:    opc = 7'b0100011;
      4'd7:    opc = 7'b0010011;
      4'd8:    opc = 7'b0110011;
      4'd9:    opc = 7'b0001111;
      4'd10:   opc = 7'b1110011;
      4'd11:   opc = 7'b1010111;
      4'd12:   opc = 7'b0010001;
      4'd13:   opc = 7'b0010011;
      4'd14:   opc = 7'b0110011;
      default: opc = 7'b1100011;
    endcase
    return {mix[31:7], opc};
  endfunction

  function automatic dec_t decode_ref(input logic [31:0] w);
    dec_t d;
    case (w[6:0])
      7'b0110111: d.opcode = OP_LUI;
      7'b0010111: d.opcode = OP_AUIPC;
      7'b1101111: d.opcode = OP_JAL;
      7'b1100111: d.opcode = OP_JALR;
      7'b1100011: d.opcode = OP_BRANCH;
      7'b0000011: d.opcode = OP_LOAD;
      7'b0100011: d.opcode = OP_STORE;
      7'b0010011: d.opcode = OP_IMM;
      7'b0110011: d.opcode = OP_REG;
      7'b0001111: d.opcode = OP_FENCE;
      7'b1110011: d.opcode = OP_SYSTEM;
      default:    d.opcode = OP_INVALID;
    endcase
    case (d.opcode)
      OP_LUI, OP_AUIPC:   d.imm = {w[31:12], 12'h000};
      OP_JAL:             d.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      OP_BRANCH:          d.imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      OP_STORE:           d.imm = 32'($signed({w[31:25], w[11:7]}));
      OP_REG, OP_INVALID: d.imm = 32'h0;
      default:            d.imm = 32'($signed(w[31:20]));
    endcase
    d.invalid = (d.opcode == OP_INVALID);
    d.rs1     = w[19:15];
    d.rd      = (d.opcode inside {OP_BRANCH, OP_STORE, OP_INVALID}) ? 5'd0 : w[11:7];
    d.rs2     = (d.opcode inside {OP_BRANCH, OP_STORE, OP_REG}) ? w[24:20] : 5'd0;
    return d;
  endfunction

  task automatic report_failure(input string line);
    $display("%s", line);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("ERROR %s: actual 0x%h, expected 0x%h", name, actual, expected));
    end
  endtask

  task automatic wait_reset_release(input int limit);
    int cycles;
    cycles = 0;
    while (reset !== 1'b0) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) report_failure("Reset was never released");
    end
  endtask

  task automatic wait_beats(input int target, input int limit);
    int cycles;
    cycles = 0;
    while (beats_checked < target) begin
      @(negedge clock);
      cycles++;
      if (cycles > limit) report_failure("Timed out waiting for decoded instructions");
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(negedge clock);
  endtask

  // Cache model, credit return and jump stimulus
  always @(posedge clock) begin
    cache_hit  <= 1'b0;
    dec_credit <= 1'b0;
    jmp_write  <= 1'b0;
    if (reset) begin
      cache_busy = 1'b0;
      credit_due.delete();
    end else begin
      // A hit or a jump ends the read
      if (jmp_write || cache_hit) begin
        cache_busy = 1'b0;
      end else if (cache_read) begin
        if (!cache_busy) begin
          cache_busy  = 1'b1;
          cache_delay = int'(rand_bits(2));
        end
        if (cache_delay == 0) begin
          cache_hit   <= 1'b1;
          cache_instr <= cache_word(cache_address);
        end else begin
          cache_delay--;
        end
      end
      if (dec_valid) credit_due.push_back(int'(rand_bits(3)));
      if (!credit_hold && credit_due.size() > 0) begin
        if (credit_due[0] == 0) begin
          void'(credit_due.pop_front());
          dec_credit <= 1'b1;
        end else begin
          credit_due[0]--;
        end
      end
      if (jump_enable && jumps_done < 6 && rand_bits(6) == 32'h0) begin
        jmp_write   <= 1'b1;
        jmp_address <= JUMP_BASE + (rand_bits(10) << 2);
        jumps_done++;
      end
    end
  end

  // Checker sees the values that held during the cycle before this edge
  always @(posedge clock) begin
    dec_t exp_dec;
    if (reset) begin
      if (reset_seen) begin
        check_value("o_cache_read", 32'(cache_read), 32'h0);
        check_value("o_dec_valid", 32'(dec_valid), 32'h0);
      end
      reset_seen    = 1'b1;
      expected_addr = RESET_ADDR;
      outstanding   = 0;
    end else begin
      if (read_waiting) begin
        check_value("o_cache_read", 32'(cache_read), 32'h1);
        check_value("o_cache_address", cache_address, prev_address);
      end
      if (dec_valid) begin
        exp_dec = decode_ref(cache_word(expected_addr));
        check_value("o_dec_address", dec_address, expected_addr);
        check_value("o_dec_opcode", 32'(dec_opcode), 32'(exp_dec.opcode));
        check_value("o_dec_rd", 32'(dec_rd), 32'(exp_dec.rd));
        check_value("o_dec_rs1", 32'(dec_rs1), 32'(exp_dec.rs1));
        check_value("o_dec_rs2", 32'(dec_rs2), 32'(exp_dec.rs2));
        check_value("o_dec_imm", dec_imm, exp_dec.imm);
        check_value("o_dec_invalid", 32'(dec_invalid), 32'(exp_dec.invalid));
        if (exp_dec.invalid) invalid_seen++;
        beats_checked++;
        outstanding++;
        expected_addr = expected_addr + 32'd4;
      end
      if (dec_credit) outstanding--;
      if (outstanding > DOWN_CREDITS) begin
        report_failure("More decoded instructions outstanding than downstream credits allow");
      end
      // Beats before the jump edge are older; the next one starts at the target
      if (jmp_write) expected_addr = jmp_address;
    end
    read_waiting = cache_read && !cache_hit && !jmp_write && !reset;
    prev_address = cache_address;
  end

  initial begin
    wait_reset_release(20);
    wait_beats(40, 400);
    jump_enable = 1'b1;
    wait_beats(beats_checked + 150, 3000);
    jump_enable = 1'b0;
    // Withhold credits until the whole front end stalls
    credit_hold = 1'b1;
    run_cycles(80);
    check_value("o_cache_read", 32'(cache_read), 32'h0);
    check_value("o_dec_valid", 32'(dec_valid), 32'h0);
    if (outstanding != DOWN_CREDITS) begin
      report_failure("Outputs did not stall at the downstream credit limit");
    end
    credit_hold = 1'b0;
    wait_beats(beats_checked + 40, 600);
    if (jumps_done > 0 && invalid_seen > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      report_failure("Run saw no jump or no invalid instruction");
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
common/frontend_pkg.sv
hw/fetch_loader.sv
instr_queue/instr_queue.sv
hw/instr_decoder.sv
hw/frontend_top.sv
test/tb_clock_gen.sv
test/tb_frontend.sv

// ==== Bender.yml ====
package:
  name: rv32i_frontend

sources:
  - common/frontend_pkg.sv
  - hw/fetch_loader.sv
  - instr_queue/instr_queue.sv
  - hw/instr_decoder.sv
  - hw/frontend_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_frontend.sv
